//--- src/rvv_rob_pkg.sv
// rvv backend package
// sizes, opcodes and the payload types passed between dispatch, lanes and the ROB
`default_nettype none

package rvv_rob_pkg;

  // ROB geometry
  localparam int rob_depth  = 8;
  localparam int rob_idx_w  = 3;
  localparam int num_rt_uop = 2;

  // execution lanes and their issue queues
  localparam int num_lane     = 2;
  localparam int lane_credits = 2;
  localparam int cred_w       = 2;
  localparam int lane_q_ptr_w = 1;

  // datapath
  localparam int data_w     = 32;
  localparam int vreg_idx_w = 5;

  // issue to writeback, in cycles
  localparam int lat_alu    = 2;
  localparam int lat_mul    = 4;
  localparam int lat_cnt_w  = 2;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_xor,
    op_sll,
    op_mul
  } uop_op_e;

  // epoch flips on each flush so late results can be dropped
  typedef struct packed {
    logic                 epoch;
    logic [rob_idx_w-1:0] idx;
  } rob_tag_t;

  typedef struct packed {
    logic [vreg_idx_w-1:0] rd;
    uop_op_e               op;
  } dp2rob_t;

  typedef struct packed {
    uop_op_e           op;
    logic [data_w-1:0] src_a;
    logic [data_w-1:0] src_b;
    rob_tag_t          tag;
  } dp2lane_t;

  typedef struct packed {
    rob_tag_t          tag;
    logic [data_w-1:0] data;
  } lane2rob_t;

  typedef struct packed {
    logic [vreg_idx_w-1:0] rd;
    logic [data_w-1:0]     data;
    logic                  trap;
  } rob2rt_t;

endpackage

`default_nettype wire

//--- src/rvv_rob_ifs.sv
// backend interfaces
// ROB allocation, credit-based lane issue and lane writeback
`timescale 1ns/1ps
`default_nettype none

// dispatch allocates one ROB entry per accepted uop
interface rob_alloc_if
  import rvv_rob_pkg::*;
();
  logic     valid;
  dp2rob_t  info;
  logic     ready;
  rob_tag_t tag;

  modport dispatch (output valid, output info, input ready, input tag);
  modport rob (input valid, input info, output ready, output tag);
endinterface

// no ready here, queue space is covered by credits
interface lane_issue_if
  import rvv_rob_pkg::*;
();
  logic     valid;
  dp2lane_t uop;
  logic     credit_return;

  modport dispatch (output valid, output uop, input credit_return);
  modport lane (input valid, input uop, output credit_return);
endinterface

// ROB always takes lane results
interface lane_wb_if
  import rvv_rob_pkg::*;
();
  logic      valid;
  lane2rob_t res;

  modport lane (output valid, output res);
  modport rob (input valid, input res);
endinterface

`default_nettype wire

//--- src/rvv_dispatch.sv
// uop dispatch
// allocates a ROB entry and issues the uop to the lowest lane holding a credit
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch
  import rvv_rob_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  in_valid,
  input  wire uop_op_e               in_op,
  input  wire logic [vreg_idx_w-1:0] in_rd,
  input  wire logic [data_w-1:0]     in_src_a,
  input  wire logic [data_w-1:0]     in_src_b,
  output logic                       in_ready,
  output rob_tag_t                   in_tag,
  rob_alloc_if.dispatch              alloc,
  lane_issue_if.dispatch             issue [num_lane]
);

  logic [num_lane-1:0] has_cred;
  logic [num_lane-1:0] grant;
  logic                fire;
  dp2lane_t            lane_uop;

  // lowest numbered lane with a credit wins
  always_comb begin
    grant = '0;
    for (int l = 0; l < num_lane; l++) begin
      if (has_cred[l] && grant == '0) begin
        grant[l] = 1'b1;
      end
    end
  end

  assign in_ready = alloc.ready & (|has_cred);
  assign fire     = in_valid & in_ready;
  assign in_tag   = alloc.tag;

  assign alloc.valid = in_valid & (|has_cred);
  assign alloc.info  = '{rd: in_rd, op: in_op};

  // lane uop carries the tag the ROB offers this cycle
  assign lane_uop = '{op: in_op, src_a: in_src_a, src_b: in_src_b, tag: alloc.tag};

  for (genvar l = 0; l < num_lane; l++) begin : g_lane
    logic [cred_w-1:0] cred;
    logic              take;

    assign take        = fire & grant[l];
    assign has_cred[l] = (cred != '0);

    assign issue[l].valid = take;
    assign issue[l].uop   = lane_uop;

    // send and return in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cred <= cred_w'(lane_credits);
      end else if (take != issue[l].credit_return) begin
        if (take) begin
          cred <= cred - 1'b1;
        end else begin
          cred <= cred + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/rvv_exec_lane.sv
// execution lane
// two-slot issue queue feeding a countdown stage, latency set by opcode
`timescale 1ns/1ps
`default_nettype none

module rvv_exec_lane
  import rvv_rob_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  lane_issue_if.lane issue,
  lane_wb_if.lane    wb
);

  dp2lane_t                q_mem [lane_credits];
  logic [lane_q_ptr_w-1:0] q_wptr;
  logic [lane_q_ptr_w-1:0] q_rptr;
  logic [cred_w-1:0]       q_cnt;
  dp2lane_t                head;
  logic [data_w-1:0]       head_res;

  logic                    ex_busy;
  logic [lat_cnt_w-1:0]    ex_cnt;
  logic                    ex_done;
  logic                    ex_load;
  rob_tag_t                ex_tag;
  logic [data_w-1:0]       ex_data;

  assign head    = q_mem[q_rptr];
  assign ex_done = ex_busy & (ex_cnt == '0);
  // next uop may enter while the current one writes back
  assign ex_load = (q_cnt != '0) & (~ex_busy | ex_done);

  always_comb begin
    case (head.op)
      op_add:  head_res = head.src_a + head.src_b;
      op_sub:  head_res = head.src_a - head.src_b;
      op_xor:  head_res = head.src_a ^ head.src_b;
      op_sll:  head_res = head.src_a << head.src_b[$clog2(data_w)-1:0];
      // low half of the product
      op_mul:  head_res = head.src_a * head.src_b;
      default: head_res = '0;
    endcase
  end

  // issue queue
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      q_mem[q_wptr] <= issue.uop;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wptr <= '0;
      q_rptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (issue.valid) begin
        q_wptr <= q_wptr + 1'b1;
      end
      if (ex_load) begin
        q_rptr <= q_rptr + 1'b1;
      end
      if (issue.valid && !ex_load) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (!issue.valid && ex_load) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

  // exec stage: the loaded count covers the cycles after the queue cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_busy <= 1'b0;
      ex_cnt  <= '0;
    end else if (ex_load) begin
      ex_busy <= 1'b1;
      ex_cnt  <= (head.op == op_mul) ? lat_cnt_w'(lat_mul - 2) : lat_cnt_w'(lat_alu - 2);
    end else if (ex_done) begin
      ex_busy <= 1'b0;
    end else if (ex_busy) begin
      ex_cnt <= ex_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_load) begin
      ex_tag  <= head.tag;
      ex_data <= head_res;
    end
  end

  assign wb.valid            = ex_done;
  assign wb.res              = '{tag: ex_tag, data: ex_data};
  assign issue.credit_return = ex_done;

endmodule

`default_nettype wire

//--- src/rvv_backend_rob.sv
// reorder buffer
// tracks uops in program order, collects lane results, retires in order and flushes on trap
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_rob
  import rvv_rob_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  rob_alloc_if.rob                     alloc,
  lane_wb_if.rob                       wb [num_lane],
  output logic [num_rt_uop-1:0]        rt_valid,
  output rob2rt_t [num_rt_uop-1:0]     rt_uop,
  input  wire logic [num_rt_uop-1:0]   rt_ready,
  input  wire logic                    trap_valid,
  input  wire logic [rob_idx_w-1:0]    trap_entry
);

  // entry state
  dp2rob_t              info_mem [rob_depth];
  logic [data_w-1:0]    res_mem  [rob_depth];
  logic [rob_depth-1:0] valid_q;
  logic [rob_depth-1:0] done_q;
  logic [rob_depth-1:0] trap_q;

  logic [rob_idx_w-1:0] wptr;
  logic [rob_idx_w-1:0] rptr;
  logic                 epoch;

  logic                 alloc_fire;
  logic [num_lane-1:0]  wb_valid;
  logic [num_lane-1:0]  wb_hit;
  rob_tag_t             wb_tag  [num_lane];
  logic [data_w-1:0]    wb_data [num_lane];

  logic [rob_idx_w-1:0]  rd_idx [num_rt_uop];
  logic [num_rt_uop-1:0] pop;
  logic [num_rt_uop-1:0] pop_trap;
  logic [rob_idx_w-1:0]  n_pop;
  logic                  flush;

  // full when the next slot to allocate is still in use
  assign alloc.ready = ~valid_q[wptr];
  assign alloc.tag   = '{epoch: epoch, idx: wptr};
  assign alloc_fire  = alloc.valid & alloc.ready;

  for (genvar l = 0; l < num_lane; l++) begin : g_wb
    assign wb_valid[l] = wb[l].valid;
    assign wb_tag[l]   = wb[l].res.tag;
    assign wb_data[l]  = wb[l].res.data;
    // results from before the last flush are dropped
    assign wb_hit[l]   = wb_valid[l] & (wb_tag[l].epoch == epoch) & valid_q[wb_tag[l].idx];
  end

  // retire slots, oldest first
  for (genvar k = 0; k < num_rt_uop; k++) begin : g_rt
    assign rd_idx[k] = rptr + rob_idx_w'(k);

    if (k == 0) begin : g_head
      assign rt_valid[k] = valid_q[rd_idx[k]] & done_q[rd_idx[k]];
      assign pop[k]      = rt_valid[k] & rt_ready[k];
    end else begin : g_next
      // nothing retires past a trapped uop
      assign rt_valid[k] = rt_valid[k-1] & valid_q[rd_idx[k]] & done_q[rd_idx[k]] &
                           ~trap_q[rd_idx[k-1]];
      assign pop[k]      = pop[k-1] & rt_valid[k] & rt_ready[k];
    end

    assign rt_uop[k] = '{rd:   info_mem[rd_idx[k]].rd,
                         data: res_mem[rd_idx[k]],
                         trap: trap_q[rd_idx[k]]};
    assign pop_trap[k] = pop[k] & trap_q[rd_idx[k]];
  end

  assign flush = |pop_trap;

  always_comb begin
    n_pop = '0;
    for (int k = 0; k < num_rt_uop; k++) begin
      if (pop[k]) begin
        n_pop = n_pop + rob_idx_w'(1);
      end
    end
  end

  // payload memories
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      info_mem[wptr] <= alloc.info;
    end
    for (int l = 0; l < num_lane; l++) begin
      if (wb_hit[l]) begin
        res_mem[wb_tag[l].idx] <= wb_data[l];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      done_q  <= '0;
      trap_q  <= '0;
      wptr    <= '0;
      rptr    <= '0;
      epoch   <= 1'b0;
    end else if (flush) begin
      // trapped uop left, everything younger is dropped
      valid_q <= '0;
      done_q  <= '0;
      trap_q  <= '0;
      wptr    <= '0;
      rptr    <= '0;
      epoch   <= ~epoch;
    end else begin
      for (int k = 0; k < num_rt_uop; k++) begin
        if (pop[k]) begin
          valid_q[rd_idx[k]] <= 1'b0;
          done_q[rd_idx[k]]  <= 1'b0;
          trap_q[rd_idx[k]]  <= 1'b0;
        end
      end
      if (alloc_fire) begin
        valid_q[wptr] <= 1'b1;
        done_q[wptr]  <= 1'b0;
        trap_q[wptr]  <= 1'b0;
        wptr          <= wptr + 1'b1;
      end
      for (int l = 0; l < num_lane; l++) begin
        if (wb_hit[l]) begin
          done_q[wb_tag[l].idx] <= 1'b1;
        end
      end
      // trap only marks a live entry
      if (trap_valid && valid_q[trap_entry]) begin
        trap_q[trap_entry] <= 1'b1;
      end
      rptr <= rptr + n_pop;
    end
  end

endmodule

`default_nettype wire

//--- src/rvv_backend_top.sv
// vector backend top
// dispatch, two execution lanes and the reorder buffer
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_top
  import rvv_rob_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // uop input
  input  wire logic                    in_valid,
  input  wire uop_op_e                 in_op,
  input  wire logic [vreg_idx_w-1:0]   in_rd,
  input  wire logic [data_w-1:0]       in_src_a,
  input  wire logic [data_w-1:0]       in_src_b,
  output logic                         in_ready,
  output rob_tag_t                     in_tag,
  // retire
  output logic [num_rt_uop-1:0]        rt_valid,
  output rob2rt_t [num_rt_uop-1:0]     rt_uop,
  input  wire logic [num_rt_uop-1:0]   rt_ready,
  // trap, always accepted
  input  wire logic                    trap_valid,
  input  wire logic [rob_idx_w-1:0]    trap_entry
);

  rob_alloc_if  alloc_if ();
  lane_issue_if issue_if [num_lane] ();
  lane_wb_if    wb_if    [num_lane] ();

  rvv_dispatch u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_rd    (in_rd),
    .in_src_a (in_src_a),
    .in_src_b (in_src_b),
    .in_ready (in_ready),
    .in_tag   (in_tag),
    .alloc    (alloc_if),
    .issue    (issue_if)
  );

  for (genvar l = 0; l < num_lane; l++) begin : g_lane
    rvv_exec_lane u_lane (
      .clk   (clk),
      .rst_n (rst_n),
      .issue (issue_if[l]),
      .wb    (wb_if[l])
    );
  end

  rvv_backend_rob u_rob (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc      (alloc_if),
    .wb         (wb_if),
    .rt_valid   (rt_valid),
    .rt_uop     (rt_uop),
    .rt_ready   (rt_ready),
    .trap_valid (trap_valid),
    .trap_entry (trap_entry)
  );

endmodule

`default_nettype wire

//--- tb/rvv_backend_assertions.sv
// ROB assertions
// retire hold under back-pressure, one writer per entry and no allocation into a full ROB
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_assertions
  import rvv_rob_pkg::*;
(
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic [num_rt_uop-1:0]    rt_valid,
  input wire logic [num_rt_uop-1:0]    rt_ready,
  input wire rob2rt_t [num_rt_uop-1:0] rt_uop,
  input wire logic [num_lane-1:0]      wb_hit,
  input wire rob_tag_t                 wb_tag [num_lane],
  input wire logic                     alloc_fire,
  input wire logic [num_rt_uop-1:0]    pop,
  input wire logic                     flush
);

  logic               dup_wr;
  logic [rob_idx_w:0] occ;
  logic [rob_idx_w:0] occ_nxt;

  // any pair of lanes landing on the same entry
  always_comb begin
    dup_wr = 1'b0;
    for (int i = 0; i < num_lane; i++) begin
      for (int j = i + 1; j < num_lane; j++) begin
        if (wb_hit[i] && wb_hit[j] && (wb_tag[i].idx == wb_tag[j].idx)) begin
          dup_wr = 1'b1;
        end
      end
    end
  end

  // occupancy counted from allocations and pops, apart from the valid bits
  always_comb begin
    occ_nxt = occ;
    if (alloc_fire) begin
      occ_nxt = occ_nxt + 1'b1;
    end
    for (int k = 0; k < num_rt_uop; k++) begin
      if (pop[k]) begin
        occ_nxt = occ_nxt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ <= '0;
    end else if (flush) begin
      occ <= '0;
    end else begin
      occ <= occ_nxt;
    end
  end

  a_rt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid[0] && !rt_ready[0]) |=>
      (rt_valid[0] && $stable(rt_uop[0].rd) && $stable(rt_uop[0].data)))
    else $error("retire slot 0 changed while held by back-pressure");

  a_single_writer: assert property (@(posedge clk) disable iff (!rst_n) !dup_wr)
    else $error("two lanes wrote the same ROB entry in one cycle");

  // top bit set means all entries in use
  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_fire |-> !occ[rob_idx_w])
    else $error("allocation while every ROB entry is in use");

endmodule

bind rvv_backend_rob rvv_backend_assertions u_rob_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .rt_valid   (rt_valid),
  .rt_ready   (rt_ready),
  .rt_uop     (rt_uop),
  .wb_hit     (wb_hit),
  .wb_tag     (wb_tag),
  .alloc_fire (alloc_fire),
  .pop        (pop),
  .flush      (flush)
);

`default_nettype wire

//--- tb/rvv_backend_tb.sv
// testbench for the vector backend ROB slice
// random uops through dispatch and lanes, in-order retire, back-pressure and trap flush
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_tb;
  import rvv_rob_pkg::*;

  localparam int n_order  = 40;
  localparam int n_bp     = 40;
  localparam int n_trap   = 4;
  localparam int n_after  = 20;
  localparam int wd_cycles = (n_order + n_bp + n_trap + n_after) * 20 + 200;
  localparam int rdy_high = 0;
  localparam int rdy_rand = 1;
  localparam int rdy_low  = 2;

  typedef struct {
    rob_tag_t tag;
    rob2rt_t  rt;
  } exp_uop_t;

  logic                     clk;
  logic                     rst_n;
  logic                     in_valid;
  uop_op_e                  in_op;
  logic [vreg_idx_w-1:0]    in_rd;
  logic [data_w-1:0]        in_src_a;
  logic [data_w-1:0]        in_src_b;
  logic                     in_ready;
  rob_tag_t                 in_tag;
  logic [num_rt_uop-1:0]    rt_valid;
  rob2rt_t [num_rt_uop-1:0] rt_uop;
  logic [num_rt_uop-1:0]    rt_ready;
  logic                     trap_valid;
  logic [rob_idx_w-1:0]     trap_entry;

  integer               seed = 32'hdfbd8957;
  exp_uop_t             exp_q[$];
  string                cur_test;
  int                   err_cnt;
  int                   retired;
  int                   dropped;
  logic                 accept_seen;
  logic                 exp_epoch;
  logic [rob_idx_w-1:0] exp_idx;

  rvv_backend_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_rd      (in_rd),
    .in_src_a   (in_src_a),
    .in_src_b   (in_src_b),
    .in_ready   (in_ready),
    .in_tag     (in_tag),
    .rt_valid   (rt_valid),
    .rt_uop     (rt_uop),
    .rt_ready   (rt_ready),
    .trap_valid (trap_valid),
    .trap_entry (trap_entry)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [data_w-1:0] ref_result(input uop_op_e op,
                                                   input logic [data_w-1:0] a,
                                                   input logic [data_w-1:0] b);
    logic [2*data_w-1:0] prod;
    prod = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_mul:  return prod[data_w-1:0];
      default: return '0;
    endcase
  endfunction

  task automatic check_rt_uop(input string name, input rob2rt_t exp, input rob2rt_t act);
    if (act !== exp) begin
      $display("error %s: expected rd %0d data %h trap %0b, actual rd %0d data %h trap %0b",
               name, exp.rd, exp.data, exp.trap, act.rd, act.data, act.trap);
      err_cnt++;
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
    if (act !== exp) begin
      $display("error %s: expected tag epoch %0b idx %0d, actual epoch %0b idx %0d",
               name, exp.epoch, exp.idx, act.epoch, act.idx);
      err_cnt++;
    end
  endtask

  task automatic drive_uop();
    int unsigned r;
    r = $unsigned($random(seed));
    in_op    <= uop_op_e'(r % 5);
    in_rd    <= vreg_idx_w'($random(seed));
    in_src_a <= $random(seed);
    in_src_b <= $random(seed);
    in_valid <= 1'b1;
  endtask

  task automatic set_ready(input int mode);
    case (mode)
      rdy_high: rt_ready <= '1;
      rdy_rand: rt_ready <= num_rt_uop'($random(seed));
      default:  rt_ready <= '0;
    endcase
  endtask

  // hold each uop until the monitor saw it accepted
  task automatic send_uops(input int n, input int mode);
    int sent;
    sent = 0;
    @(posedge clk);
    drive_uop();
    set_ready(mode);
    while (sent < n) begin
      @(posedge clk);
      if (accept_seen) begin
        sent++;
        if (sent < n) begin
          drive_uop();
        end else begin
          in_valid <= 1'b0;
        end
      end
      set_ready(mode);
    end
  endtask

  task automatic drain(input int mode);
    while (exp_q.size() != 0) begin
      @(posedge clk);
      set_ready(mode);
    end
  endtask

  task automatic end_test(input int n, input int errs_before);
    $display("test %s done: %0d uops sent, %0d errors", cur_test, n, err_cnt - errs_before);
  endtask

  // sampled mid-cycle, describes what happens at the next rising edge
  always @(negedge clk) begin : compare
    exp_uop_t e;
    rob_tag_t t;
    logic     live;
    accept_seen = 1'b0;
    if (rst_n) begin
      if (exp_q.size() >= rob_depth && in_ready) begin
        $display("error %s: in_ready high with %0d uops outstanding", cur_test, exp_q.size());
        err_cnt++;
      end
      live = 1'b1;
      for (int k = 0; k < num_rt_uop; k++) begin
        if (live && rt_valid[k] && rt_ready[k]) begin
          if (exp_q.size() == 0) begin
            $display("error %s: slot %0d retired a uop that should not retire", cur_test, k);
            err_cnt++;
          end else begin
            e = exp_q.pop_front();
            check_rt_uop(cur_test, e.rt, rt_uop[k]);
            retired++;
            // trapped uop leaves, younger ones are gone
            if (e.rt.trap) begin
              dropped += exp_q.size();
              exp_q.delete();
              exp_epoch = ~exp_epoch;
              exp_idx = '0;
              live = 1'b0;
            end
          end
        end else begin
          live = 1'b0;
        end
      end
      accept_seen = in_valid && in_ready;
      if (accept_seen) begin
        t.epoch = exp_epoch;
        t.idx = exp_idx;
        check_tag(cur_test, t, in_tag);
        e.tag = t;
        e.rt.rd = in_rd;
        e.rt.data = ref_result(in_op, in_src_a, in_src_b);
        e.rt.trap = 1'b0;
        exp_q.push_back(e);
        exp_idx = exp_idx + 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", wd_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int       errs;
    rob_tag_t flush_tag;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = op_add;
    in_rd       = '0;
    in_src_a    = '0;
    in_src_b    = '0;
    rt_ready    = '0;
    trap_valid  = 1'b0;
    trap_entry  = '0;
    err_cnt     = 0;
    retired     = 0;
    dropped     = 0;
    accept_seen = 1'b0;
    exp_epoch   = 1'b0;
    exp_idx     = '0;
    cur_test    = "reset";
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "retire_order";
    errs = err_cnt;
    send_uops(n_order, rdy_high);
    drain(rdy_high);
    end_test(n_order, errs);

    cur_test = "back_pressure";
    errs = err_cnt;
    send_uops(n_bp, rdy_rand);
    drain(rdy_rand);
    end_test(n_bp, errs);

    // retire held so the second uop is still in the ROB when trapped
    cur_test = "trap_flush";
    errs = err_cnt;
    send_uops(n_trap, rdy_low);
    @(posedge clk);
    trap_valid <= 1'b1;
    trap_entry <= exp_q[1].tag.idx;
    exp_q[1].rt.trap = 1'b1;
    @(posedge clk);
    trap_valid <= 1'b0;
    drain(rdy_high);
    // after the flush the ROB offers entry 0 of the new epoch
    @(negedge clk);
    flush_tag.epoch = exp_epoch;
    flush_tag.idx   = exp_idx;
    check_tag(cur_test, flush_tag, in_tag);
    end_test(n_trap, errs);

    cur_test = "after_flush";
    errs = err_cnt;
    send_uops(n_after, rdy_rand);
    drain(rdy_high);
    end_test(n_after, errs);

    $display("summary: 4 tests, %0d uops retired, %0d flushed, %0d errors",
             retired, dropped, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/rvv_rob_pkg.sv
src/rvv_rob_ifs.sv
src/rvv_dispatch.sv
src/rvv_exec_lane.sv
src/rvv_backend_rob.sv
src/rvv_backend_top.sv
tb/rvv_backend_assertions.sv
tb/rvv_backend_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the backend testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --assert --top-module rvv_backend_tb -f verilog.f -o sim_bin \
  && ./obj_dir/sim_bin > sim.log 2>&1 \
  || echo "build or simulation ended with an error status" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
